//--- regFile.f
+incdir+test
rtl/regFilePkg.sv
rtl/gprBank.sv
rtl/fprBank.sv
rtl/operandSelect.sv
rtl/regFileTop.sv
test/regFileTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f regFile.f --top-module regFileTb -o regFileSim \
	&& ./obj_dir/regFileSim | tee /dev/stderr | grep -F "Everything OK" > /dev/null \
	&& echo "PASS" || { echo "FAIL"; exit 1; }

//--- test/regFileModel.svh
// Register file reference model
`ifndef REGFILEMODEL_SVH
`define REGFILEMODEL_SVH

regWord_t liveLow [8];		// R0..R7 as the core sees them
regWord_t spareLow [8];		// R0B..R7B
regWord_t upperGpr [8];		// R8..R15
regWord_t frontFp [16];		// FR0..FR15
regWord_t backFp [16];		// XF0..XF15
logic lastGprSel;		// Bank bits seen at the last edge
logic lastFprSel;

task automatic resetModel();
	for (int i = 0; i < 16; i++)
	begin
		frontFp[i] = '0;
		backFp[i] = '0;
		if (i < 8)
		begin
			liveLow[i] = '0;
			spareLow[i] = '0;
			upperGpr[i] = '0;
		end
	end
	lastGprSel = 1'b0;
	lastFprSel = 1'b0;
endtask

// Bank flips take priority over writes to the flipped registers
task automatic applyEdge(input regWrite_t wr, input logic gprSel, input logic fprSel);
	int n;
	regWord_t held;
	logic [31:0] hi;
	logic [31:0] lo;
	n = int'(wr.id);
	hi = wr.value[63:32];
	lo = wr.value[31:0];
	for (int i = 0; i < 16; i++)
	begin
		if (i < 8 && gprSel != lastGprSel)
		begin
			held = liveLow[i];
			liveLow[i] = spareLow[i];
			spareLow[i] = held;
		end
		if (fprSel != lastFprSel)
		begin
			held = frontFp[i];
			frontFp[i] = backFp[i];
			backFp[i] = held;
		end
	end
	if (gprSel == lastGprSel && n < 8)
		liveLow[n] = lo;
	else if (gprSel == lastGprSel && n >= 16 && n < 24)
		spareLow[n - 16] = lo;
	else if (n >= 8 && n < 16)
		upperGpr[n - 8] = lo;		// Never banked
	if (fprSel == lastFprSel && n >= 32 && n < 48)
	begin
		if (!wr.isPair)
			frontFp[n - 32] = lo;
		else if (n % 2 == 0)
		begin
			frontFp[n - 32] = hi;
			frontFp[n - 31] = lo;
		end
		else
		begin
			backFp[n - 33] = hi;	// Odd FR id names the XF pair
			backFp[n - 32] = lo;
		end
	end
	else if (fprSel == lastFprSel && n >= 48 && n < 64 && !wr.isPair)
		backFp[n - 48] = lo;
	lastGprSel = gprSel;
	lastFprSel = fprSel;
endtask

function automatic logic [63:0] expectedRead(input regId_t id, input logic pairRead,
		input regWord_t imm);
	int n;
	logic [63:0] result;
	n = int'(id);
	result = '0;				// Zero, shadow, XF and unknown
	if (n < 8)
		result[31:0] = liveLow[n];
	else if (n < 16)
		result[31:0] = upperGpr[n - 8];
	else if (n >= 32 && n < 48 && pairRead && n % 2 == 0)
		result = {frontFp[n - 32], frontFp[n - 31]};
	else if (n >= 32 && n < 48 && pairRead)
		result = {backFp[n - 33], backFp[n - 32]};
	else if (n >= 32 && n < 48)
		result[31:0] = frontFp[n - 32];
	else if (n == 64)
		result[31:0] = imm;
	return result;
endfunction

`endif

//--- test/regFileTb.sv
// Register file testbench
`timescale 1ns/1ps
`default_nettype none

module regFileTb;
	import regFilePkg::*;

	localparam int sweepCycles = 256;	// Every id single and then paired
	localparam int totalCycles = 20256;
	localparam int resetLimit = 40;		// Edges allowed for reset release

	logic clock;
	logic reset;
	regWrite_t write;
	logic gprBankSel;
	logic fprBankSel;
	logic loadPair;
	regWord_t immediate;
	regId_t idRs;
	regId_t idRt;
	regValue_t valueRs;
	regValue_t valueRt;

	logic [31:0] lcgState = 32'd86689;
	int errorsRs = 0;
	int errorsRt = 0;
	int timeouts = 0;
	logic released;

	`include "regFileModel.svh"

	regFileTop i_dut (.*);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial
	begin
		reset = 1'b1;
		repeat (10) @(posedge clock);
		#1 reset = 1'b0;
	end

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Range and index come from the upper LCG bits
	function automatic regId_t randomId();
		logic [31:0] r;
		r = nextRandom();
		case (r[31:29])
			3'd0, 3'd1: return {3'b000, r[27:24]};	// R0..R15
			3'd2: return {4'b0010, r[26:24]};		// R0B..R7B
			3'd3, 3'd4: return {3'b010, r[27:24]};	// FR
			3'd5: return {3'b011, r[27:24]};		// XF
			3'd6: return {6'b100000, r[24]};		// Immediate or zero
			default: return r[28] ? {2'b11, r[27:23]} : {4'b0011, r[26:24]};
		endcase
	endfunction

	task automatic runCycle(input int index);
		logic [31:0] r;
		logic [63:0] expectRs;
		logic [63:0] expectRt;
		applyEdge(write, gprBankSel, fprBankSel);	// Edge that just passed
		#1;
		r = nextRandom();
		immediate = nextRandom();
		if (index < sweepCycles)
		begin
			idRs = index[6:0];
			idRt = ~index[6:0];
			loadPair = index[7];
		end
		else
		begin
			write.id = randomId();
			write.value = {nextRandom(), nextRandom()};
			write.isPair = r[16];
			loadPair = r[17];
			if (r[23:20] == 4'd0)
				gprBankSel = ~gprBankSel;		// About one in sixteen
			if (r[27:24] == 4'd0)
				fprBankSel = ~fprBankSel;
			idRs = randomId();
			idRt = randomId();
		end
		#8;						// Just before the next edge
		expectRs = expectedRead(idRs, loadPair, immediate);
		expectRt = expectedRead(idRt, loadPair, immediate);
		assert (valueRs === expectRs)
		else
		begin
			errorsRs++;
			$display("error at %0t: valueRs (id %0d) expected %h actual %h",
				$time, idRs, expectRs, valueRs);
		end
		assert (valueRt === expectRt)
		else
		begin
			errorsRt++;
			$display("error at %0t: valueRt (id %0d) expected %h actual %h",
				$time, idRt, expectRt, valueRt);
		end
		@(posedge clock);
	endtask

	initial
	begin
		write = '0;
		write.id = 7'd127;				// Unknown id that writes nothing
		gprBankSel = 1'b0;
		fprBankSel = 1'b0;
		loadPair = 1'b0;
		immediate = '0;
		idRs = idZero;
		idRt = idZero;
		resetModel();
		released = 1'b0;
		for (int t = 0; t < resetLimit && !released; t++)
		begin
			@(posedge clock);
			released = !reset;
		end
		if (released)
		begin
			for (int cycle = 0; cycle < totalCycles; cycle++)
				runCycle(cycle);
		end
		else
		begin
			timeouts++;
			$display("Reset was still asserted after %0d clock cycles", resetLimit);
		end
		$display("Errors: valueRs %0d, valueRt %0d, timeouts %0d", errorsRs, errorsRt, timeouts);
		if (errorsRs + errorsRt + timeouts == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/regFileTop.sv
// Register file top level
`timescale 1ns/1ps
`default_nettype none

module regFileTop (
	input wire logic clock,
	input wire logic reset,
	input wire regFilePkg::regWrite_t write,
	input wire logic gprBankSel,
	input wire logic fprBankSel,
	input wire logic loadPair,
	input wire regFilePkg::regWord_t immediate,
	input wire regFilePkg::regId_t idRs,
	input wire regFilePkg::regId_t idRt,
	output regFilePkg::regValue_t valueRs,
	output regFilePkg::regValue_t valueRt
);
	import regFilePkg::*;

	gprView_t gprView;		// Visible R0..R15
	fprView_t fprView;		// FR then XF

	gprBank gprBankI (
		.clock(clock),
		.reset(reset),
		.write(write),
		.bankSel(gprBankSel),
		.view(gprView)
	);

	fprBank fprBankI (
		.clock(clock),
		.reset(reset),
		.write(write),
		.bankSel(fprBankSel),
		.view(fprView)
	);

	// Both read ports share one selector design
	operandSelect selRs (
		.id(idRs),
		.loadPair(loadPair),
		.immediate(immediate),
		.gprView(gprView),
		.fprView(fprView),
		.value(valueRs)
	);

	operandSelect selRt (
		.id(idRt),
		.loadPair(loadPair),
		.immediate(immediate),
		.gprView(gprView),
		.fprView(fprView),
		.value(valueRt)
	);

endmodule

`default_nettype wire

//--- rtl/operandSelect.sv
// Operand read selector
`timescale 1ns/1ps
`default_nettype none

module operandSelect (
	input wire regFilePkg::regId_t id,
	input wire logic loadPair,
	input wire regFilePkg::regWord_t immediate,
	input wire regFilePkg::gprView_t gprView,
	input wire regFilePkg::fprView_t fprView,
	output regFilePkg::regValue_t value
);
	import regFilePkg::*;

	logic [6:0] gprOffset;		// Id relative to R0
	logic [6:0] frOffset;		// Id relative to FR0
	logic [4:0] pairHi;		// Flat index into fprView
	logic [4:0] pairLo;

	assign gprOffset = id - idR0;
	assign frOffset = id - idFR0;

	// Odd FR id selects the XF pair through bit 4 of the view index
	assign pairHi = {frOffset[0], frOffset[3:1], 1'b0};
	assign pairLo = {frOffset[0], frOffset[3:1], 1'b1};

	always_comb
	begin
		value = '0;					// Zero, shadow, XF and unknown ids
		if (gprOffset < gprCount)
		begin
			value.single.word = gprView[gprOffset[3:0]];
		end
		else if (frOffset < fprCount)
		begin
			if (loadPair)
			begin
				value.pair.hi = fprView[pairHi];
				value.pair.lo = fprView[pairLo];
			end
			else
			begin
				value.single.word = fprView[frOffset[3:0]];	// FR half only
			end
		end
		else if (id == idImm)
		begin
			value.single.word = immediate;
		end
	end

endmodule

`default_nettype wire

//--- rtl/fprBank.sv
// Floating register bank
`timescale 1ns/1ps
`default_nettype none

module fprBank (
	input wire logic clock,
	input wire logic reset,
	input wire regFilePkg::regWrite_t write,
	input wire logic bankSel,
	output regFilePkg::fprView_t view
);
	import regFilePkg::*;

	regWord_t frRegs [fprCount];		// Front bank FR0..FR15
	regWord_t xfRegs [fprCount];		// Back bank XF0..XF15
	logic bankStored;			// Bank bit seen at last edge
	logic bankSwap;

	logic [6:0] frOffset;			// Id relative to FR0
	logic [6:0] xfOffset;			// Id relative to XF0
	logic hitFr;
	logic hitXf;
	logic [3:0] frIdx;
	logic [3:0] xfIdx;
	logic [3:0] pairEven;			// Even register of the pair
	logic [3:0] pairOdd;

	assign bankSwap = bankSel ^ bankStored;

	assign frOffset = write.id - idFR0;
	assign xfOffset = write.id - idXF0;
	assign hitFr = frOffset < fprCount;
	assign hitXf = xfOffset < fprCount;
	assign frIdx = frOffset[3:0];
	assign xfIdx = xfOffset[3:0];
	assign pairEven = {frIdx[3:1], 1'b0};
	assign pairOdd = {frIdx[3:1], 1'b1};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			bankStored <= 1'b0;
			for (int i = 0; i < fprCount; i++)
			begin
				frRegs[i] <= '0;
				xfRegs[i] <= '0;
			end
		end
		else
		begin
			bankStored <= bankSel;
			if (bankSwap)
			begin
				// Whole FR and XF trade places and the write is lost
				for (int i = 0; i < fprCount; i++)
				begin
					frRegs[i] <= xfRegs[i];
					xfRegs[i] <= frRegs[i];
				end
			end
			else if (write.isPair)
			begin
				// Pair mode only decodes FR ids
				if (hitFr && !frIdx[0])
				begin
					frRegs[pairEven] <= write.value.pair.hi;	// DRn names an FR pair
					frRegs[pairOdd] <= write.value.pair.lo;
				end
				else if (hitFr)
				begin
					xfRegs[pairEven] <= write.value.pair.hi;	// XDn odd id picks XF
					xfRegs[pairOdd] <= write.value.pair.lo;
				end
			end
			else
			begin
				if (hitFr)
					frRegs[frIdx] <= write.value.single.word;
				if (hitXf)
					xfRegs[xfIdx] <= write.value.single.word;
			end
		end
	end

	always_comb
	begin
		for (int i = 0; i < fprCount; i++)
		begin
			view[i] = frRegs[i];
			view[i + fprCount] = xfRegs[i];		// XF follows FR
		end
	end

endmodule

`default_nettype wire

//--- rtl/gprBank.sv
// General register bank
`timescale 1ns/1ps
`default_nettype none

module gprBank (
	input wire logic clock,
	input wire logic reset,
	input wire regFilePkg::regWrite_t write,
	input wire logic bankSel,
	output regFilePkg::gprView_t view
);
	import regFilePkg::*;

	regWord_t activeLow [bankedCount];		// R0..R7 as seen now
	regWord_t shadowLow [bankedCount];		// The other R0..R7 copy
	regWord_t highRegs [gprCount - bankedCount];	// R8..R15, never banked
	logic bankStored;				// Bank bit seen at last edge
	logic bankSwap;					// Bank bit just changed

	logic [6:0] gprOffset;				// Id relative to R0
	logic [6:0] shadowOffset;			// Id relative to R0B
	logic hitActive;
	logic hitShadow;
	logic hitHigh;

	assign bankSwap = bankSel ^ bankStored;

	assign gprOffset = write.id - idR0;
	assign shadowOffset = write.id - idR0B;
	assign hitActive = gprOffset < bankedCount;
	assign hitShadow = shadowOffset < bankedCount;	// Ids below R0B wrap high
	assign hitHigh = (gprOffset >= bankedCount) && (gprOffset < gprCount);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			bankStored <= 1'b0;
			for (int i = 0; i < bankedCount; i++)
			begin
				activeLow[i] <= '0;
				shadowLow[i] <= '0;
			end
			for (int i = 0; i < gprCount - bankedCount; i++)
			begin
				highRegs[i] <= '0;
			end
		end
		else
		begin
			bankStored <= bankSel;
			if (bankSwap)
			begin
				// Trade the two copies and drop any R0..R7 write
				for (int i = 0; i < bankedCount; i++)
				begin
					activeLow[i] <= shadowLow[i];
					shadowLow[i] <= activeLow[i];
				end
			end
			else
			begin
				if (hitActive)
					activeLow[gprOffset[2:0]] <= write.value.single.word;
				if (hitShadow)
					shadowLow[shadowOffset[2:0]] <= write.value.single.word;
			end
			if (hitHigh)
				highRegs[gprOffset[2:0]] <= write.value.single.word;	// 8..15 map to 0..7
		end
	end

	always_comb
	begin
		for (int i = 0; i < bankedCount; i++)
		begin
			view[i] = activeLow[i];			// Shadow copy is never visible
			view[i + bankedCount] = highRegs[i];
		end
	end

endmodule

`default_nettype wire

//--- rtl/regFilePkg.sv
// Register file shared types
`default_nettype none

package regFilePkg;

	typedef logic [31:0] regWord_t;		// One architectural register
	typedef logic [6:0] regId_t;		// Unified register id

	localparam int gprCount = 16;		// R0..R15
	localparam int bankedCount = 8;		// R0..R7 have a shadow copy
	localparam int fprCount = 16;		// Per floating bank FR or XF

	// Each id range starts on a 16 boundary
	localparam regId_t idR0 = 7'd0;		// R0..R15 at 0..15
	localparam regId_t idR15 = 7'd15;
	localparam regId_t idR0B = 7'd16;	// Write-only shadow R0B..R7B
	localparam regId_t idR7B = 7'd23;
	localparam regId_t idFR0 = 7'd32;	// FR0..FR15 at 32..47
	localparam regId_t idFR15 = 7'd47;
	localparam regId_t idXF0 = 7'd48;	// XF0..XF15 at 48..63
	localparam regId_t idXF15 = 7'd63;
	localparam regId_t idImm = 7'd64;	// Immediate pseudo-operand
	localparam regId_t idZero = 7'd65;	// Constant zero
	// Anything else is unknown and reads as zero

	// Paired view with hi in the even register of the pair
	typedef struct packed {
		regWord_t hi;
		regWord_t lo;
	} regPair_t;

	// Single view with data in the low word only
	typedef struct packed {
		regWord_t pad;		// Zero on reads
		regWord_t word;
	} regSingle_t;

	typedef union packed {
		regPair_t pair;		// 64-bit floating transfers
		regSingle_t single;	// Ordinary 32-bit transfers
	} regValue_t;

	// Write request on the one write port
	typedef struct packed {
		regId_t id;
		regValue_t value;
		logic isPair;		// Paired floating write
	} regWrite_t;

	// Visible R0..R15
	typedef regWord_t [gprCount - 1:0] gprView_t;

	// FR0..FR15 in 0..15 then XF0..XF15 in 16..31
	typedef regWord_t [2 * fprCount - 1:0] fprView_t;

endpackage

`default_nettype wire
